/* rtl/cgra_defs.svh */
`ifndef CGRA_DEFS_SVH
`define CGRA_DEFS_SVH

// ========================================
// Array geometry
// ========================================

// Number of PE columns, each with its own LSU and scratchpad
`define CGRA_COLS 4

// Number of PE rows between an LSU and its own result path
`define CGRA_ROWS 2

// ========================================
// Datapath and memories
// ========================================

`define DATA_W 32

// Words per column scratchpad
// Lower half holds operands, upper half holds results
`define VEC_DEPTH 16

// ========================================
// Host bus
// ========================================

// Word address width of the Wishbone port
`define WB_ADR_W 10

`endif

/* rtl/cgra_pkg.sv */
`include "cgra_defs.svh"

package cgra_pkg;

    // ========================================
    // Width types
    // ========================================

    typedef logic [`DATA_W-1:0]             data_t;
    typedef logic [$clog2(`VEC_DEPTH)-1:0]  vec_idx_t;
    // Run length 0 to 8, only 1 to 8 start a run
    typedef logic [3:0]                     vec_len_t;
    typedef logic [$clog2(`CGRA_COLS)-1:0]  col_idx_t;
    typedef logic [`WB_ADR_W-1:0]           wb_adr_t;

    // ========================================
    // Encodings
    // ========================================

    typedef enum logic [2:0] {
        OP_PASS = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_MUL  = 3'd3,
        OP_XOR  = 3'd4
    } pe_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } ctrl_state_t;

    // ========================================
    // Bundles
    // ========================================

    // Matches configuration word bits 18:16 and 15:0
    typedef struct packed {
        pe_op_t      op;
        logic [15:0] imm;
    } pe_cfg_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        data_t   dat;
    } wb_req_t;

    typedef struct packed {
        logic     en;
        logic     we;
        col_idx_t col;
        vec_idx_t addr;
        data_t    wdata;
    } mem_req_t;

endpackage

/* rtl/cgra_top.sv */
`include "cgra_defs.svh"

module cgra_top import cgra_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t wb_req,
    output data_t   wb_dat_r,
    output logic    wb_ack
);
    mem_req_t host_req;
    data_t    host_rdata;
    pe_cfg_t  pe_cfg    [`CGRA_ROWS][`CGRA_COLS];
    logic     run_start;
    vec_len_t run_len;
    logic     run_done;
    mem_req_t lsu_req   [`CGRA_COLS];
    data_t    lsu_rdata [`CGRA_COLS];

    wb_cfg_port u_port (
        .clk        (clk        ),
        .reset      (reset      ),
        .wb_req     (wb_req     ),
        .wb_dat_r   (wb_dat_r   ),
        .wb_ack     (wb_ack     ),
        .host_req   (host_req   ),
        .host_rdata (host_rdata ),
        .pe_cfg     (pe_cfg     ),
        .run_start  (run_start  ),
        .run_len    (run_len    ),
        .run_done   (run_done   )
    );

    scratch_mem u_mem (
        .clk        (clk        ),
        .host_req   (host_req   ),
        .host_rdata (host_rdata ),
        .lsu_req    (lsu_req    ),
        .lsu_rdata  (lsu_rdata  )
    );

    pe_array u_array (
        .clk        (clk        ),
        .reset      (reset      ),
        .pe_cfg     (pe_cfg     ),
        .run_start  (run_start  ),
        .run_len    (run_len    ),
        .lsu_req    (lsu_req    ),
        .lsu_rdata  (lsu_rdata  ),
        .run_done   (run_done   )
    );

endmodule

/* rtl/lsu.sv */
`include "cgra_defs.svh"

module lsu import cgra_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  col_idx_t col,
    input  logic     run_start,
    input  vec_len_t run_len,
    output mem_req_t mem_req,
    input  data_t    mem_rdata,
    output data_t    to_pe,
    output logic     to_pe_valid,
    input  data_t    from_pe,
    input  logic     from_pe_valid,
    output logic     store_done
);
    ctrl_state_t state;
    vec_idx_t    rd_idx;
    vec_idx_t    st_idx;
    vec_len_t    rd_left;
    vec_len_t    st_left;
    logic        rd_req;
    logic        st_req;

    // Stores win the single port, a read waits for the next free cycle
    assign st_req     = from_pe_valid && (state != ST_IDLE);
    assign rd_req     = (state == ST_RUN) && !st_req;
    assign store_done = st_req && (st_left == vec_len_t'(1));

    always_comb begin
        mem_req.en    = rd_req || st_req;
        mem_req.we    = st_req;
        mem_req.col   = col;
        mem_req.addr  = st_req ? st_idx : rd_idx;
        mem_req.wdata = from_pe;
    end

    // Read data arrives one cycle after the request, along with its valid
    assign to_pe = mem_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            to_pe_valid <= 1'b0;
            rd_idx      <= '0;
            rd_left     <= '0;
            st_idx      <= '0;
            st_left     <= '0;
        end else begin
            to_pe_valid <= rd_req;
            case (state)
                ST_IDLE: begin
                    if (run_start && (run_len != '0)) begin
                        state   <= ST_RUN;
                        rd_idx  <= '0;
                        rd_left <= run_len;
                        st_idx  <= vec_idx_t'(`VEC_DEPTH / 2);
                        st_left <= run_len;
                    end
                end
                ST_RUN: begin
                    if (rd_req) begin
                        rd_idx  <= rd_idx + 1'b1;
                        rd_left <= rd_left - 1'b1;
                        if (rd_left == vec_len_t'(1)) state <= ST_DRAIN;
                    end
                end
                default: ;
            endcase
            if (st_req) begin
                st_idx  <= st_idx + 1'b1;
                st_left <= st_left - 1'b1;
                if (st_left == vec_len_t'(1)) state <= ST_IDLE;
            end
        end
    end

endmodule

/* rtl/pe.sv */
`include "cgra_defs.svh"

module pe import cgra_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  pe_cfg_t cfg,
    input  data_t   n_in,
    input  logic    n_valid,
    output data_t   s_out,
    output logic    s_valid
);
    data_t imm_ext;
    data_t result;

    // Immediate is unsigned and zero extended to the word width
    assign imm_ext = {{(`DATA_W - 16){1'b0}}, cfg.imm};

    // ========================================
    // Operation select
    // ========================================

    always_comb begin
        case (cfg.op)
            OP_PASS: result = n_in;
            OP_ADD:  result = n_in + imm_ext;
            OP_SUB:  result = n_in - imm_ext;
            // Only the low word of the product is kept
            OP_MUL:  result = n_in * imm_ext;
            OP_XOR:  result = n_in ^ imm_ext;
            default: result = n_in;
        endcase
    end

    // ========================================
    // South output register
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            s_valid <= 1'b0;
        end else begin
            s_valid <= n_valid;
        end
    end

    // Data only moves with a valid word, idle cycles hold the last result
    always_ff @(posedge clk) begin
        if (n_valid) begin
            s_out <= result;
        end
    end

endmodule

/* rtl/pe_array.sv */
`include "cgra_defs.svh"

module pe_array import cgra_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  pe_cfg_t  pe_cfg    [`CGRA_ROWS][`CGRA_COLS],
    input  logic     run_start,
    input  vec_len_t run_len,
    output mem_req_t lsu_req   [`CGRA_COLS],
    input  data_t    lsu_rdata [`CGRA_COLS],
    output logic     run_done
);
    // Level 0 is the LSU output, level CGRA_ROWS is the bottom row output
    data_t                 link_data  [`CGRA_ROWS+1][`CGRA_COLS];
    logic                  link_valid [`CGRA_ROWS+1][`CGRA_COLS];
    logic [`CGRA_COLS-1:0] col_done;

    for (genvar c = 0; c < `CGRA_COLS; c++) begin : g_col
        lsu u_lsu (
            .clk           (clk                         ),
            .reset         (reset                       ),
            .col           (col_idx_t'(c)               ),
            .run_start     (run_start                   ),
            .run_len       (run_len                     ),
            .mem_req       (lsu_req[c]                  ),
            .mem_rdata     (lsu_rdata[c]                ),
            .to_pe         (link_data[0][c]             ),
            .to_pe_valid   (link_valid[0][c]            ),
            .from_pe       (link_data[`CGRA_ROWS][c]    ),
            .from_pe_valid (link_valid[`CGRA_ROWS][c]   ),
            .store_done    (col_done[c]                 )
        );

        for (genvar r = 0; r < `CGRA_ROWS; r++) begin : g_row
            pe u_pe (
                .clk     (clk                 ),
                .reset   (reset               ),
                .cfg     (pe_cfg[r][c]        ),
                .n_in    (link_data[r][c]     ),
                .n_valid (link_valid[r][c]    ),
                .s_out   (link_data[r+1][c]   ),
                .s_valid (link_valid[r+1][c]  )
            );
        end
    end

    // Columns run in lockstep, so column 0 marks the end of the run
    assign run_done = col_done[0];

endmodule

/* rtl/scratch_mem.sv */
`include "cgra_defs.svh"

module scratch_mem import cgra_pkg::*; (
    input  logic     clk,
    input  mem_req_t host_req,
    output data_t    host_rdata,
    input  mem_req_t lsu_req   [`CGRA_COLS],
    output data_t    lsu_rdata [`CGRA_COLS]
);
    data_t    host_q [`CGRA_COLS];
    col_idx_t host_sel_q;

    // One bank per column, each with a host port and its own LSU port
    for (genvar c = 0; c < `CGRA_COLS; c++) begin : g_bank
        data_t ram [`VEC_DEPTH];
        logic  host_hit;

        assign host_hit = host_req.en && (host_req.col == col_idx_t'(c));

        always_ff @(posedge clk) begin
            if (host_hit) begin
                if (host_req.we) begin
                    ram[host_req.addr] <= host_req.wdata;
                end else begin
                    host_q[c] <= ram[host_req.addr];
                end
            end
            // The LSU only touches its own column, so no word is written twice
            if (lsu_req[c].en) begin
                if (lsu_req[c].we) begin
                    ram[lsu_req[c].addr] <= lsu_req[c].wdata;
                end else begin
                    lsu_rdata[c] <= ram[lsu_req[c].addr];
                end
            end
        end
    end

    // ========================================
    // Host read return
    // ========================================

    always_ff @(posedge clk) begin
        if (host_req.en) begin
            host_sel_q <= host_req.col;
        end
    end

    assign host_rdata = host_q[host_sel_q];

endmodule

/* rtl/wb_cfg_port.sv */
`include "cgra_defs.svh"

module wb_cfg_port import cgra_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  wb_req_t  wb_req,
    output data_t    wb_dat_r,
    output logic     wb_ack,
    output mem_req_t host_req,
    input  data_t    host_rdata,
    output pe_cfg_t  pe_cfg [`CGRA_ROWS][`CGRA_COLS],
    output logic     run_start,
    output vec_len_t run_len,
    input  logic     run_done
);
    localparam int PE_W  = $clog2(`CGRA_ROWS * `CGRA_COLS);
    localparam int CFG_W = $bits(pe_cfg_t);

    logic            take;
    logic [1:0]      region;
    logic [PE_W-1:0] pe_num;
    vec_len_t        start_len;
    logic            start_ok;
    logic            busy;
    logic            done;
    ctrl_state_t     state;
    logic            rd_mem_q;
    data_t           rd_data_q;
    data_t           cfg_word;

    // A new access is taken only when ack is low, so each one acks exactly once
    assign take      = wb_req.cyc && wb_req.stb && !wb_ack;
    assign region    = wb_req.adr[`WB_ADR_W-1 -: 2];
    assign pe_num    = wb_req.adr[PE_W-1:0];
    assign start_len = wb_req.dat[3:0];
    assign busy      = (state != ST_IDLE);
    assign start_ok  = take && wb_req.we && (region == 2'd2) && !busy &&
                       (start_len != '0) && (start_len <= vec_len_t'(`VEC_DEPTH / 2));

    // Scratchpad request goes out with stb so the word is back in the ack cycle
    always_comb begin
        host_req.en    = take && (region == 2'd0) && !(wb_req.we && busy);
        host_req.we    = wb_req.we && !busy;
        host_req.col   = wb_req.adr[5:4];
        host_req.addr  = wb_req.adr[3:0];
        host_req.wdata = wb_req.dat;
    end

    always_comb begin
        cfg_word = '0;
        for (int r = 0; r < `CGRA_ROWS; r++) begin
            for (int c = 0; c < `CGRA_COLS; c++) begin
                if (pe_num == PE_W'(r * `CGRA_COLS + c)) begin
                    cfg_word = {{(`DATA_W - CFG_W){1'b0}}, pe_cfg[r][c]};
                end
            end
        end
    end

    // ========================================
    // Bus handshake, configuration and run control
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            rd_mem_q  <= 1'b0;
            run_start <= 1'b0;
            run_len   <= '0;
            done      <= 1'b0;
            state     <= ST_IDLE;
            for (int r = 0; r < `CGRA_ROWS; r++) begin
                for (int c = 0; c < `CGRA_COLS; c++) begin
                    pe_cfg[r][c] <= '{op: OP_PASS, imm: '0};
                end
            end
        end else begin
            wb_ack    <= take;
            run_start <= start_ok;
            if (take) begin
                rd_mem_q <= (region == 2'd0);
            end
            if (start_ok) begin
                run_len <= start_len;
                done    <= 1'b0;
            end
            if (take && wb_req.we && (region == 2'd1) && !busy) begin
                for (int r = 0; r < `CGRA_ROWS; r++) begin
                    for (int c = 0; c < `CGRA_COLS; c++) begin
                        if (pe_num == PE_W'(r * `CGRA_COLS + c)) begin
                            pe_cfg[r][c] <= pe_cfg_t'(wb_req.dat[CFG_W-1:0]);
                        end
                    end
                end
            end
            case (state)
                ST_IDLE: if (run_start) state <= ST_RUN;
                ST_RUN: begin
                    if (run_done) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            case (region)
                2'd1:    rd_data_q <= cfg_word;
                2'd2:    rd_data_q <= {{(`DATA_W - 2){1'b0}}, done, busy};
                default: rd_data_q <= '0;
            endcase
        end
    end

    assign wb_dat_r = rd_mem_q ? host_rdata : rd_data_q;

endmodule

/* sources.f */
+incdir+rtl
rtl/cgra_pkg.sv
rtl/wb_cfg_port.sv
rtl/scratch_mem.sv
rtl/lsu.sv
rtl/pe.sv
rtl/pe_array.sv
rtl/cgra_top.sv
test/cgra_props.sv
test/cgra_tb.sv

/* test/cgra_props.sv */
module cgra_props import cgra_pkg::*; (
    input logic    clk,
    input logic    reset,
    input wb_req_t wb_req,
    input logic    wb_ack,
    input logic    busy,
    input logic    done
);
    timeunit 1ns;
    timeprecision 1ps;

    // ========================================
    // Wishbone handshake
    // ========================================

    ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else $error("ack stayed high for two cycles");

    // Ack answers a request seen in the cycle before
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack without a preceding cyc and stb");

    // ========================================
    // Run control
    // ========================================

    busy_done_excl: assert property (@(posedge clk) disable iff (reset) !(busy && done))
        else $error("busy and done are both set");

endmodule

bind wb_cfg_port cgra_props props_i (
    .clk    (clk   ),
    .reset  (reset ),
    .wb_req (wb_req),
    .wb_ack (wb_ack),
    .busy   (busy  ),
    .done   (done  )
);

/* test/cgra_tb.sv */
`include "cgra_defs.svh"

module cgra_tb import cgra_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          PERIOD       = 40;
    localparam logic [31:0] SEED         = 32'heb404016;
    localparam int          ACK_TIMEOUT  = 20;
    localparam int          DONE_TIMEOUT = 200;
    localparam int          HALF         = `VEC_DEPTH / 2;
    localparam wb_adr_t     ADR_CTRL     = wb_adr_t'(10'h200);

    logic    clk;
    logic    reset;
    wb_req_t wb_req;
    data_t   wb_dat_r;
    logic    wb_ack;

    logic [31:0] lfsr;
    int          checks;
    int          errors;
    bit          hung;
    data_t       mem_model [`CGRA_COLS][`VEC_DEPTH];
    pe_cfg_t     cfg_model [`CGRA_ROWS][`CGRA_COLS];

    cgra_top dut_i (
        .clk      (clk     ),
        .reset    (reset   ),
        .wb_req   (wb_req  ),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack  )
    );

    always #(PERIOD / 2) clk = ~clk;

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1
    function automatic data_t rand_bits(int n);
        data_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic pe_cfg_t rand_cfg();
        pe_cfg_t cfg;
        cfg.op  = pe_op_t'(3'(rand_bits(3) % 5));
        cfg.imm = 16'(rand_bits(16));
        return cfg;
    endfunction

    // One PE step of the reference model with the immediate taken as unsigned
    function automatic data_t apply_op(pe_cfg_t cfg, data_t x);
        data_t imm;
        imm = data_t'(cfg.imm);
        case (cfg.op)
            OP_ADD:  return x + imm;
            OP_SUB:  return x - imm;
            OP_MUL:  return x * imm;
            OP_XOR:  return x ^ imm;
            default: return x;
        endcase
    endfunction

    function automatic wb_adr_t mem_adr(int col, int idx);
        return wb_adr_t'({2'd0, 2'd0, 2'(col), 4'(idx)});
    endfunction

    function automatic wb_adr_t cfg_adr(int row, int col);
        return wb_adr_t'({2'd1, 5'd0, 3'(row * `CGRA_COLS + col)});
    endfunction

    task automatic check_data(data_t got, data_t exp, string what);
        if (hung) return;
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(data_t got, data_t exp);
        if (hung) return;
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: status busy %b done %b, expected busy %b done %b",
                     $time, got[0], got[1], exp[0], exp[1]);
        end
    endtask

    // ========================================
    // Wishbone master
    // ========================================

    // Entered and left 2 ns after a rising edge
    task automatic wb_access(logic we, wb_adr_t adr, data_t dat, output data_t rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        if (hung) return;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        rdata  = wb_dat_r;
        wb_req = '0;
        if (!wb_ack) begin
            hung = 1'b1;
            $display("No acknowledge within %0d cycles for address %h", ACK_TIMEOUT, adr);
        end
    endtask

    task automatic wb_write(wb_adr_t adr, data_t dat);
        data_t unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(wb_adr_t adr, output data_t dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    task automatic wait_done();
        data_t st;
        int    polls;
        st    = '0;
        polls = 0;
        while (!st[1] && !hung && polls < DONE_TIMEOUT) begin
            wb_read(ADR_CTRL, st);
            polls++;
        end
        if (!hung && !st[1]) begin
            hung = 1'b1;
            $display("Run did not finish within %0d status polls", DONE_TIMEOUT);
        end
    endtask

    // ========================================
    // Test steps
    // ========================================

    task automatic write_operands(int n);
        for (int c = 0; c < `CGRA_COLS; c++) begin
            for (int i = 0; i < n; i++) begin
                mem_model[c][i] = rand_bits(32);
                wb_write(mem_adr(c, i), mem_model[c][i]);
            end
        end
    endtask

    task automatic write_cfgs(bit random_ops);
        for (int r = 0; r < `CGRA_ROWS; r++) begin
            for (int c = 0; c < `CGRA_COLS; c++) begin
                cfg_model[r][c] = random_ops ? rand_cfg() : pe_cfg_t'{op: OP_PASS, imm: '0};
                wb_write(cfg_adr(r, c), data_t'(cfg_model[r][c]));
            end
        end
    endtask

    task automatic check_cfgs();
        data_t rd;
        for (int r = 0; r < `CGRA_ROWS; r++) begin
            for (int c = 0; c < `CGRA_COLS; c++) begin
                wb_read(cfg_adr(r, c), rd);
                check_data(rd, data_t'(cfg_model[r][c]), $sformatf("PE %0d,%0d config", r, c));
            end
        end
    endtask

    task automatic check_results(int n);
        data_t rd;
        data_t v;
        wait_done();
        wb_read(ADR_CTRL, rd);
        check_status(rd, 32'h2);
        for (int c = 0; c < `CGRA_COLS; c++) begin
            for (int i = 0; i < n; i++) begin
                v = mem_model[c][i];
                for (int r = 0; r < `CGRA_ROWS; r++) begin
                    v = apply_op(cfg_model[r][c], v);
                end
                mem_model[c][HALF + i] = v;
                wb_read(mem_adr(c, HALF + i), rd);
                check_data(rd, v, $sformatf("column %0d result %0d", c, i));
            end
        end
    endtask

    task automatic report_test(int num, string name, int base);
        $display("test %0d %s finished with %0d errors", num, name, errors - base);
    endtask

    initial begin
        data_t rd;
        data_t word;
        int    n;
        int    base;
        clk    = 1'b0;
        reset  = 1'b1;
        wb_req = '0;
        lfsr   = SEED;
        checks = 0;
        errors = 0;
        hung   = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        base = errors;
        wb_read(ADR_CTRL, rd);
        check_status(rd, '0);
        foreach (cfg_model[r, c]) cfg_model[r][c] = '{op: OP_PASS, imm: '0};
        check_cfgs();
        report_test(1, "reset state", base);

        base = errors;
        for (int c = 0; c < `CGRA_COLS; c++) begin
            for (int i = 0; i < `VEC_DEPTH; i++) begin
                mem_model[c][i] = rand_bits(32);
                wb_write(mem_adr(c, i), mem_model[c][i]);
            end
        end
        for (int c = 0; c < `CGRA_COLS; c++) begin
            for (int i = 0; i < `VEC_DEPTH; i++) begin
                wb_read(mem_adr(c, i), rd);
                check_data(rd, mem_model[c][i], $sformatf("column %0d word %0d", c, i));
            end
        end
        // Upper bits of a configuration word are not stored
        foreach (cfg_model[r, c]) begin
            word            = rand_bits(32);
            word[18:16]     = 3'(rand_bits(3) % 5);
            cfg_model[r][c] = pe_cfg_t'(word[18:0]);
            wb_write(cfg_adr(r, c), word);
        end
        check_cfgs();
        report_test(2, "register readback", base);

        base = errors;
        write_cfgs(1'b0);
        n = 1 + int'(rand_bits(3));
        write_operands(n);
        wb_write(ADR_CTRL, data_t'(n));
        check_results(n);
        report_test(3, "pass-through run", base);

        base = errors;
        repeat (4) begin
            write_cfgs(1'b1);
            n = 1 + int'(rand_bits(3));
            write_operands(n);
            wb_write(ADR_CTRL, data_t'(n));
            check_results(n);
        end
        report_test(4, "random op runs", base);

        base = errors;
        write_operands(HALF);
        wb_write(ADR_CTRL, data_t'(HALF));
        wb_write(mem_adr(1, 3), ~mem_model[1][3]);
        wb_write(cfg_adr(0, 2), ~data_t'(cfg_model[0][2]));
        wb_write(ADR_CTRL, 32'd4);
        check_results(HALF);
        check_cfgs();
        wb_read(mem_adr(1, 3), rd);
        check_data(rd, mem_model[1][3], "column 1 word 3 after blocked write");
        wb_write(ADR_CTRL, 32'd0);
        wb_read(ADR_CTRL, rd);
        check_status(rd, 32'h2);
        wb_write(ADR_CTRL, 32'd9);
        wb_read(ADR_CTRL, rd);
        check_status(rd, 32'h2);
        report_test(5, "blocked writes and bad starts", base);

        $display("checks %0d, errors %0d%s", checks, errors,
                 hung ? ", stopped early by a timeout" : "");
        if (errors == 0 && !hung) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
